//--- line_sequencer.sv
// line sequencer
// accepts line_start when idle, walks 32 slots of 16 enables,
// lets the draw pipeline drain, then pulses line_done for one clock
`timescale 1ns/1ps
`default_nettype none

module line_sequencer import video_timing_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        line_start,
    input  logic [7:0]  vpos,
    output logic        line_done,
    obj_scan_if.seq_mp  scan
);

    localparam int DRAIN_W = $clog2(PIPE_DRAIN + 1);

    line_state_t        state;
    logic [DRAIN_W-1:0] drain_cnt;   // enables spent in LS_DRAIN
    logic               run_q;
    logic               last_pxl;    // slot 31 pixel 15 on an enable
    logic               accept;

    assign last_pxl = scan.cen && scan.objcnt == 5'(NUM_SLOTS - 1)
                      && scan.pxlcnt == 4'(SLOT_PIXELS - 1);
    assign accept   = state == LS_IDLE && line_start;  // ignored mid line

    always_ff @(posedge clk) begin
        line_done <= 1'b0;   // single clock pulse
        if (reset) begin
            state     <= LS_IDLE;
            run_q     <= 1'b0;
            drain_cnt <= '0;
        end else begin
            case (state)
                LS_IDLE: begin
                    if (accept) begin
                        state <= LS_RUN;
                        run_q <= 1'b1;
                    end
                end
                LS_RUN: begin
                    if (last_pxl) begin
                        state     <= LS_DRAIN;
                        run_q     <= 1'b0;
                        drain_cnt <= '0;
                    end
                end
                LS_DRAIN: begin
                    if (scan.cen) begin
                        drain_cnt <= drain_cnt + 1'b1;
                        if (drain_cnt == DRAIN_W'(PIPE_DRAIN - 1)) begin
                            state     <= LS_IDLE;
                            line_done <= 1'b1;
                        end
                    end
                end
                default: state <= LS_IDLE;
            endcase
        end
    end

    // line number held for the whole line
    always_ff @(posedge clk) begin
        if (accept) begin
            scan.vline <= vpos;
        end
    end

    assign scan.run = run_q;

    // every line starts from slot 0 pixel 0
    run_starts_at_zero: assert property (@(posedge clk) disable iff (reset)
        $rose(scan.run) |-> scan.objcnt == '0 && scan.pxlcnt == '0);

endmodule

`default_nettype wire

//--- obj_draw.sv
// object drawer
// latches the four attribute bytes of each slot, tests the line zone,
// fetches four planar words, unpacks them into colour indices and
// sends one palette colour with its column per pixel enable
`timescale 1ns/1ps
`default_nettype none

module obj_draw import obj_types_pkg::*, video_timing_pkg::*; #(
    parameter int GFX_AW = 10
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              obj_enable,
    obj_scan_if.draw_mp       scan,
    output logic [6:0]        attr_addr,
    input  attr_byte_t        attr_data,
    output logic [GFX_AW-1:0] gfx_addr,
    input  gfx_word_t         gfx_data,
    output logic [7:0]        pal_addr,
    input  pal_entry_t        pal_data,
    output pal_entry_t        pxl,
    output logic [8:0]        posx
);

    localparam int         CODE_W  = GFX_AW - 6;  // row and word take 6 bits
    localparam logic [3:0] LOAD_PH = 4'd5;        // word 0 of a slot is back

    // front end, slot being read
    logic [10:0] code;
    logic [7:0]  obj_y;
    logic [7:0]  x_lo;
    logic        x_hi;
    pal_id_t     fr_pal;
    logic        fr_zone;      // slot covers vline
    logic [7:0]  y_cur;
    logic [7:0]  top;
    logic [7:0]  row;
    logic        in_zone;

    // back end, slot being drawn
    logic [3:0]  ph;           // pixel phase, keeps going through the drain
    pal_id_t     bk_pal;
    logic        bk_zone;
    gfx_word_t   shf;          // plane shifters
    col_idx_t    col_idx;
    logic [8:0]  col_x;        // column of the index on pal_addr
    logic [8:0]  col_d;        // column of the palette read
    logic        zone_d;

    assign attr_addr = {scan.objcnt, scan.pxlcnt[1:0]};  // byte n read at count n

    // attribute latch, byte n returns at count n+1
    always_ff @(posedge clk) begin
        if (scan.cen) begin
            case (scan.pxlcnt)
                4'(ATTR_CODE_LO + 1): code[7:0] <= attr_data;
                4'(ATTR_CODE_HI + 1): begin
                    code[10:8] <= attr_data[7:5];
                    x_hi       <= attr_data[4];
                    fr_pal     <= attr_data[3:0];
                end
                4'(ATTR_Y + 1): obj_y <= attr_data;
                4'(ATTR_X + 1): x_lo  <= attr_data;
                default: ;
            endcase
            // graphics word pxlcnt[3:2] of the current slot
            if (scan.pxlcnt[1:0] == 2'd3) begin
                gfx_addr <= {code[CODE_W-1:0], row[3:0], scan.pxlcnt[3:2]};
            end
        end
    end

    // y is still on the bus at count 3, so word 0 needs no extra wait
    assign y_cur   = (scan.pxlcnt == 4'(ATTR_Y + 1)) ? attr_data : obj_y;
    assign top     = y_cur - 8'(Y_BIAS);
    assign row     = scan.vline - top;
    assign in_zone = scan.vline >= top && row < 8'(OBJ_HEIGHT);

    // zone flag handed over once per slot, cleared so idle slots stay empty
    always_ff @(posedge clk) begin
        if (reset) begin
            fr_zone <= 1'b0;
        end else if (scan.cen) begin
            if (scan.pxlcnt == 4'(ATTR_Y + 1)) begin
                fr_zone <= in_zone;
            end else if (ph == LOAD_PH) begin
                fr_zone <= 1'b0;
            end
        end
    end

    // follows pxlcnt during the line, free runs after it
    always_ff @(posedge clk) begin
        if (reset) begin
            ph <= '0;
        end else if (scan.cen) begin
            ph <= scan.run ? scan.pxlcnt + 4'd1 : ph + 4'd1;
        end
    end

    // slot handover to the back end
    always_ff @(posedge clk) begin
        if (reset) begin
            bk_zone <= 1'b0;
            bk_pal  <= '0;
        end else if (scan.cen && ph == LOAD_PH) begin
            bk_zone <= fr_zone;
            bk_pal  <= fr_zone ? fr_pal : pal_id_t'(0);  // empty slot uses palette 0
        end
    end

    // plane unpacking and column count
    always_ff @(posedge clk) begin
        if (scan.cen) begin
            if (ph[1:0] == LOAD_PH[1:0]) begin
                shf <= gfx_data;            // every fourth enable
            end else begin
                shf.z <= shf.z << 1;
                shf.y <= shf.y << 1;
                shf.x <= shf.x << 1;
                shf.w <= shf.w << 1;
            end
            col_x <= (ph == LOAD_PH) ? {x_hi, x_lo} : col_x + 9'd1;  // 9 bit wrap
            col_d <= col_x;                 // matches the palette read
        end
    end

    assign col_idx  = bk_zone ? pixel_idx(shf, 0) : TRANSPARENT_IDX;
    assign pal_addr = {bk_pal, col_idx};

    // output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            zone_d <= 1'b0;
            posx   <= POSX_NONE;
        end else if (scan.cen) begin
            zone_d <= bk_zone;
            posx   <= (obj_enable && zone_d) ? col_d : POSX_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (scan.cen) begin
            pxl <= obj_enable ? pal_data : 8'hff;
        end
    end

    posx_off_when_disabled: assert property (@(posedge clk) disable iff (reset)
        scan.cen && !obj_enable |=> posx == POSX_NONE);

endmodule

`default_nettype wire

//--- obj_engine.sv
// object engine top level
// pixel timer, line sequencer, drawer and the attribute,
// graphics and palette memories behind plain ports
`timescale 1ns/1ps
`default_nettype none

module obj_engine import obj_types_pkg::*; #(
    parameter int CEN_DIV = 4,
    parameter int GFX_AW  = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        line_start,
    input  logic [7:0]  vpos,
    input  logic        obj_enable,
    input  logic [10:0] prog_addr,
    input  logic [15:0] prog_data,
    input  logic        attr_we,
    input  logic        gfx_we,
    input  logic        pal_we,
    output logic [7:0]  pxl,
    output logic [8:0]  posx,
    output logic        pxl_cen,
    output logic        line_done
);

    obj_scan_if scan ();

    logic [6:0]        attr_addr;
    attr_byte_t        attr_data;
    logic [GFX_AW-1:0] gfx_addr;
    gfx_word_t         gfx_data;
    logic [7:0]        pal_addr;
    pal_entry_t        pal_data;

    assign pxl_cen = scan.cen;   // pxl and posx valid here

    pixel_timer #(
        .CEN_DIV (CEN_DIV)
    ) u_timer (
        .clk   (clk),
        .reset (reset),
        .scan  (scan.timer_mp)
    );

    line_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .vpos       (vpos),
        .line_done  (line_done),
        .scan       (scan.seq_mp)
    );

    obj_draw #(
        .GFX_AW (GFX_AW)
    ) u_draw (
        .clk        (clk),
        .reset      (reset),
        .obj_enable (obj_enable),
        .scan       (scan.draw_mp),
        .attr_addr  (attr_addr),
        .attr_data  (attr_data),
        .gfx_addr   (gfx_addr),
        .gfx_data   (gfx_data),
        .pal_addr   (pal_addr),
        .pal_data   (pal_data),
        .pxl        (pxl),
        .posx       (posx)
    );

    // 32 objects x 4 bytes
    prog_ram #(
        .word_t (attr_byte_t),
        .AW     (7)
    ) u_attr (
        .clk     (clk),
        .cen     (scan.cen),
        .we      (attr_we),
        .wr_addr (prog_addr[6:0]),
        .rd_addr (attr_addr),
        .din     (attr_byte_t'(prog_data[7:0])),
        .q       (attr_data)
    );

    // full 16 bit planar words
    prog_ram #(
        .word_t (gfx_word_t),
        .AW     (GFX_AW)
    ) u_gfx (
        .clk     (clk),
        .cen     (scan.cen),
        .we      (gfx_we),
        .wr_addr (prog_addr[GFX_AW-1:0]),
        .rd_addr (gfx_addr),
        .din     (gfx_word_t'(prog_data)),
        .q       (gfx_data)
    );

    // 16 palettes x 16 colours
    prog_ram #(
        .word_t (pal_entry_t),
        .AW     (8)
    ) u_pal (
        .clk     (clk),
        .cen     (scan.cen),
        .we      (pal_we),
        .wr_addr (prog_addr[7:0]),
        .rd_addr (pal_addr),
        .din     (pal_entry_t'(prog_data[7:0])),
        .q       (pal_data)
    );

endmodule

`default_nettype wire

//--- obj_scan_if.sv
// object scan interface
// pixel enable, slot counters and line state shared by
// the pixel timer, line sequencer and object drawer
`timescale 1ns/1ps
`default_nettype none

interface obj_scan_if;

    logic       cen;      // pixel clock enable
    logic [3:0] pxlcnt;   // pixel within slot
    logic [4:0] objcnt;   // slot within line
    logic       run;      // slots being walked
    logic [7:0] vline;    // line being drawn

    modport timer_mp (
        output cen,
        output pxlcnt,
        output objcnt,
        input  run
    );

    modport seq_mp (
        output run,
        output vline,
        input  cen,
        input  pxlcnt,
        input  objcnt
    );

    modport draw_mp (
        input cen,
        input pxlcnt,
        input objcnt,
        input run,
        input vline
    );

endinterface

`default_nettype wire

//--- obj_types_pkg.sv
// object types package
// attribute bytes, planar graphics words and palette colours
// shared by the object memories and the drawer
`default_nettype none

package obj_types_pkg;

    typedef logic [7:0] attr_byte_t;   // one byte of the attribute table

    // four 4-bit planes, pixel n of the word sits in bit 3-n of each plane
    typedef struct packed {
        logic [3:0] z;
        logic [3:0] y;
        logic [3:0] x;
        logic [3:0] w;
    } gfx_word_t;

    typedef logic [7:0] pal_entry_t;   // palette output colour
    typedef logic [3:0] col_idx_t;     // colour index inside one palette
    typedef logic [3:0] pal_id_t;      // palette select

    localparam col_idx_t TRANSPARENT_IDX = 4'hf;  // empty slots
    localparam int OBJ_BYTES  = 4;
    localparam int OBJ_HEIGHT = 16;
    localparam int OBJ_WIDTH  = 16;
    localparam int Y_BIAS     = 2;     // stored y minus this is the top line

    // attribute byte order inside one object
    localparam int ATTR_CODE_LO = 0;   // code[7:0]
    localparam int ATTR_CODE_HI = 1;   // code[10:8] in 7:5, x[8] in 4, palette in 3:0
    localparam int ATTR_Y       = 2;
    localparam int ATTR_X       = 3;   // x[7:0]

    // colour index of pixel n, plane w gives the msb
    function automatic col_idx_t pixel_idx(gfx_word_t word, int n);
        return {word.w[3-n], word.x[3-n], word.y[3-n], word.z[3-n]};
    endfunction

endpackage

`default_nettype wire

//--- pixel_timer.sv
// pixel timer
// divides clk into free running pixel enables and counts
// pixels within a slot and slots within a line while run is high
`timescale 1ns/1ps
`default_nettype none

module pixel_timer import video_timing_pkg::*; #(
    parameter int CEN_DIV = 4
) (
    input logic          clk,
    input logic          reset,
    obj_scan_if.timer_mp scan
);

    localparam int DIV_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam int PXL_W = $clog2(SLOT_PIXELS);
    localparam int CNT_W = $clog2(NUM_SLOTS * SLOT_PIXELS);

    logic [DIV_W-1:0] div_cnt;    // clocks within one enable period
    logic [CNT_W-1:0] line_cnt;   // {slot, pixel}

    // enable divider, free running
    always_ff @(posedge clk) begin
        if (reset || div_cnt == DIV_W'(CEN_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign scan.cen = div_cnt == DIV_W'(CEN_DIV - 1);  // last clock of the period

    // slot/pixel counter, held at zero outside a line
    always_ff @(posedge clk) begin
        if (reset || !scan.run) begin
            line_cnt <= '0;
        end else if (scan.cen) begin
            line_cnt <= line_cnt + 1'b1;   // wraps to 0 after slot 31 pixel 15
        end
    end

    assign scan.pxlcnt = line_cnt[PXL_W-1:0];
    assign scan.objcnt = line_cnt[CNT_W-1:PXL_W];

    // run only drops on an enable, so pixel steps stay on the enable grid
    pxl_on_cen: assert property (@(posedge clk) disable iff (reset)
        $changed(scan.pxlcnt) |-> $past(scan.cen));

endmodule

`default_nettype wire

//--- prog_ram.sv
// programmable memory
// one write port on clk, registered read on the pixel enable
// the word type selects attribute, graphics or palette storage
`timescale 1ns/1ps
`default_nettype none

module prog_ram #(
    parameter type word_t = logic [7:0],
    parameter int  AW     = 8
) (
    input  logic          clk,
    input  logic          cen,
    input  logic          we,
    input  logic [AW-1:0] wr_addr,
    input  logic [AW-1:0] rd_addr,
    input  word_t         din,
    output word_t         q
);

    word_t mem [2**AW];

    // loading port, any clock
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

    // read data appears on the next enable
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

    wr_addr_known: assert property (@(posedge clk)
        we |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

//--- tb_obj_engine.sv
// testbench for the object engine
// loads graphics, palette and a 32 entry object table, draws a list of
// lines and checks every drawn pixel against a model of the attribute rules
`timescale 1ns/1ps
`default_nettype none

module tb_obj_engine import obj_types_pkg::*, video_timing_pkg::*; ();

    localparam int         CEN_DIV     = 4;      // obj_engine defaults
    localparam int         GFX_AW      = 10;
    localparam int         CLK_NS      = 100;
    localparam int         NUM_LINES   = 9;
    localparam logic [7:0] TEST_LINE   = 8'd100; // line the cover flags refer to
    localparam int         LINE_CLKS   = (NUM_SLOTS * SLOT_PIXELS + PIPE_DRAIN + 20) * CEN_DIV;
    localparam int         LOAD_CLKS   = OBJ_BYTES * NUM_SLOTS + 2**GFX_AW + 2 * 256;
    localparam int         WATCHDOG_NS = ((NUM_LINES + 1) * LINE_CLKS + LOAD_CLKS + 2000) * CLK_NS;

    logic        clk;
    logic        reset;
    logic        line_start;
    logic [7:0]  vpos;
    logic        obj_enable;
    logic [10:0] prog_addr;
    logic [15:0] prog_data;
    logic        attr_we;
    logic        gfx_we;
    logic        pal_we;
    logic [7:0]  pxl;
    logic [8:0]  posx;
    logic        pxl_cen;
    logic        line_done;

    logic [15:0] gfx_mem [2**GFX_AW];   // copies of what was loaded
    logic [7:0]  pal_mem [256];
    logic [10:0] obj_code [NUM_SLOTS];  // object table
    logic [8:0]  obj_x    [NUM_SLOTS];
    logic [7:0]  obj_y    [NUM_SLOTS];
    logic [3:0]  obj_pal  [NUM_SLOTS];
    logic        obj_cov  [NUM_SLOTS];  // expected to cover TEST_LINE
    logic [7:0]  ln_vpos   [NUM_LINES]; // line table
    logic        ln_en     [NUM_LINES];
    logic        ln_busy   [NUM_LINES];
    logic        ln_reload [NUM_LINES];
    logic [8:0]  exp_posx [$];          // expected pixel stream
    logic [7:0]  exp_pxl  [$];
    integer      seed = 32'hcfcbcf79;
    int          errors = 0;
    int          checks = 0;
    int          seen = 0;              // valid pixels in the current line
    int          done_cnt = 0;
    logic        in_line = 1'b0;

    obj_engine UUT (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .vpos       (vpos),
        .obj_enable (obj_enable),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .attr_we    (attr_we),
        .gfx_we     (gfx_we),
        .pal_we     (pal_we),
        .pxl        (pxl),
        .posx       (posx),
        .pxl_cen    (pxl_cen),
        .line_done  (line_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // one write, we bits are {attr, gfx, pal}
    task automatic prog_write(input logic [2:0] sel, input int addr, input logic [15:0] data);
        @(posedge clk);
        #10;
        prog_addr = addr[10:0];
        prog_data = data;
        {attr_we, gfx_we, pal_we} = sel;
    endtask

    task automatic prog_stop();
        @(posedge clk);
        #10;
        {attr_we, gfx_we, pal_we} = 3'b000;
    endtask

    task automatic load_palette();
        logic [15:0] r;
        for (int a = 0; a < 256; a++) begin
            r = $random(seed);
            pal_mem[a] = r[7:0];
            prog_write(3'b001, a, {8'h00, r[7:0]});
        end
        prog_stop();
    endtask

    task automatic load_all();
        logic [15:0] r;
        for (int a = 0; a < 2**GFX_AW; a++) begin
            r = $random(seed);
            gfx_mem[a] = r;
            prog_write(3'b010, a, r);
        end
        load_palette();
        for (int s = 0; s < NUM_SLOTS; s++) begin   // byte layout of one object
            prog_write(3'b100, OBJ_BYTES * s + ATTR_CODE_LO, {8'h00, obj_code[s][7:0]});
            prog_write(3'b100, OBJ_BYTES * s + ATTR_CODE_HI,
                       {8'h00, obj_code[s][10:8], obj_x[s][8], obj_pal[s]});
            prog_write(3'b100, OBJ_BYTES * s + ATTR_Y, {8'h00, obj_y[s]});
            prog_write(3'b100, OBJ_BYTES * s + ATTR_X, {8'h00, obj_x[s][7:0]});
        end
        prog_stop();
    endtask

    task automatic set_obj(input int s, input logic [10:0] code, input logic [8:0] x,
                           input logic [7:0] y, input logic [3:0] pal, input logic cov);
        obj_code[s] = code;
        obj_x[s]    = x;
        obj_y[s]    = y;
        obj_pal[s]  = pal;
        obj_cov[s]  = cov;
    endtask

    task automatic set_line(input int i, input logic [7:0] v, input logic en,
                            input logic busy, input logic reload);
        ln_vpos[i]   = v;
        ln_en[i]     = en;
        ln_busy[i]   = busy;
        ln_reload[i] = reload;
    endtask

    task automatic fill_tables();
        set_obj(0,  11'h003, 9'h010, 8'd95,  4'h1, 1'b1);  // row 7
        set_obj(1,  11'h005, 9'h020, 8'd30,  4'h2, 1'b0);
        set_obj(2,  11'h10a, 9'h135, 8'd102, 4'h3, 1'b1);  // x high bit, row 0
        set_obj(3,  11'h00c, 9'h0f0, 8'd87,  4'h4, 1'b1);  // row 15
        set_obj(4,  11'h001, 9'h050, 8'd103, 4'h5, 1'b0);  // one line below
        set_obj(5,  11'h002, 9'h060, 8'd86,  4'h6, 1'b0);  // one line above
        set_obj(6,  11'h7ff, 9'h1f8, 8'd90,  4'h7, 1'b1);  // column wraps to 0
        set_obj(7,  11'h004, 9'h0a0, 8'd52,  4'h8, 1'b0);  // rows on lines 50..65
        set_obj(8,  11'h006, 9'h000, 8'd240, 4'h9, 1'b0);
        set_obj(9,  11'h007, 9'h0c8, 8'd195, 4'ha, 1'b0);
        set_obj(10, 11'h008, 9'h1a0, 8'd200, 4'hb, 1'b0);
        set_obj(11, 11'h009, 9'h030, 8'd240, 4'hc, 1'b0);
        set_obj(12, 11'h00b, 9'h070, 8'd140, 4'hd, 1'b0);
        set_obj(13, 11'h00d, 9'h080, 8'd99,  4'he, 1'b1);
        set_obj(14, 11'h00e, 9'h090, 8'd240, 4'hf, 1'b0);
        set_obj(15, 11'h00f, 9'h0b0, 8'd20,  4'h0, 1'b0);
        set_obj(16, 11'h010, 9'h0c0, 8'd188, 4'h1, 1'b0);
        set_obj(17, 11'h011, 9'h0d0, 8'd240, 4'h2, 1'b0);
        set_obj(18, 11'h012, 9'h0e0, 8'd101, 4'h3, 1'b1);
        set_obj(19, 11'h013, 9'h101, 8'd94,  4'h4, 1'b1);
        set_obj(20, 11'h014, 9'h110, 8'd240, 4'h5, 1'b0);
        set_obj(21, 11'h015, 9'h120, 8'd10,  4'h6, 1'b0);
        set_obj(22, 11'h016, 9'h140, 8'd120, 4'h7, 1'b0);
        set_obj(23, 11'h017, 9'h150, 8'd97,  4'h8, 1'b1);
        set_obj(24, 11'h018, 9'h160, 8'd240, 4'h9, 1'b0);
        set_obj(25, 11'h019, 9'h170, 8'd160, 4'ha, 1'b0);
        set_obj(26, 11'h01a, 9'h180, 8'd199, 4'hb, 1'b0);
        set_obj(27, 11'h01b, 9'h190, 8'd240, 4'hc, 1'b0);
        set_obj(28, 11'h01c, 9'h000, 8'd100, 4'hd, 1'b1);
        set_obj(29, 11'h01d, 9'h1b0, 8'd180, 4'he, 1'b0);
        set_obj(30, 11'h01e, 9'h1c0, 8'd104, 4'hf, 1'b0);
        set_obj(31, 11'h01f, 9'h1e0, 8'd88,  4'h0, 1'b1);
        set_line(0, TEST_LINE, 1'b1, 1'b0, 1'b0);
        set_line(1, 8'd50,     1'b1, 1'b0, 1'b0);  // top row of slot 7
        set_line(2, 8'd65,     1'b1, 1'b0, 1'b0);  // bottom row
        set_line(3, 8'd49,     1'b1, 1'b0, 1'b0);
        set_line(4, 8'd66,     1'b1, 1'b0, 1'b0);
        set_line(5, TEST_LINE, 1'b0, 1'b0, 1'b0);  // drawing off
        set_line(6, TEST_LINE, 1'b1, 1'b1, 1'b0);  // second line_start mid line
        set_line(7, TEST_LINE, 1'b1, 1'b0, 1'b1);  // new palette first
        set_line(8, 8'd200,    1'b1, 1'b0, 1'b0);
    endtask

    // expected pixels of one line, slot order, 16 per covering object
    task automatic build_expected(input logic [7:0] line, output int n);
        logic [7:0]  top;
        logic [7:0]  row;
        logic        cov;
        logic [15:0] word;
        logic [3:0]  idx;
        logic [8:0]  col;
        int          b;
        n = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            top = obj_y[s] - Y_BIAS;
            row = line - top;
            cov = int'(line) >= int'(top) && int'(line) < int'(top) + OBJ_HEIGHT;
            if (line == TEST_LINE) check($sformatf("cover[%0d]", s), obj_cov[s], cov);
            if (cov) begin
                for (int j = 0; j < OBJ_WIDTH; j++) begin
                    word = gfx_mem[{obj_code[s][GFX_AW-7:0], row[3:0], j[3:2]}];
                    b    = 3 - j % 4;
                    idx  = {word[b], word[4+b], word[8+b], word[12+b]};  // w plane is msb
                    col  = obj_x[s] + j;                                   // 9 bit wrap
                    exp_posx.push_back(col);
                    exp_pxl.push_back(pal_mem[{obj_pal[s], idx}]);
                end
                n += OBJ_WIDTH;
            end
        end
    endtask

    task automatic pulse_start(input logic [7:0] v);
        @(posedge clk);
        #10;
        vpos       = v;
        line_start = 1'b1;
        @(posedge clk);
        #10;
        line_start = 1'b0;
    endtask

    task automatic run_line(input int i);
        int n;
        int err0;
        int target;
        err0 = errors;
        if (ln_reload[i]) load_palette();
        @(posedge clk);
        #10;
        obj_enable = ln_en[i];
        repeat (2) @(posedge pxl_cen);   // output stage follows the enable
        n = 0;
        exp_posx.delete();
        exp_pxl.delete();
        if (ln_en[i]) build_expected(ln_vpos[i], n);
        seen    = 0;
        target  = done_cnt + 1;
        in_line = 1'b1;
        pulse_start(ln_vpos[i]);
        if (ln_busy[i]) begin
            repeat (40) @(posedge pxl_cen);
            pulse_start(8'd50);          // must be ignored
        end
        wait (done_cnt == target);
        if (ln_busy[i]) begin
            repeat (LINE_CLKS) @(posedge clk);   // a second line would finish in here
            check("line_done count", target, done_cnt);
        end
        in_line = 1'b0;
        check("pixels left", 0, exp_posx.size());
        check("valid pixels", n, seen);
        $display("line test %0d vpos %0d enable %0b: %0d pixels, %s", i, ln_vpos[i],
                 ln_en[i], seen, (errors == err0) ? "ok" : "mismatch");
    endtask

    // outputs are steady mid period, sampled on the falling edge
    always @(negedge clk) begin
        if (line_done) done_cnt = done_cnt + 1;
        if (pxl_cen === 1'b1) begin
            if (in_line && !obj_enable) begin
                check("posx", POSX_NONE, posx);
                check("pxl", 8'hff, pxl);
            end else if (posx !== POSX_NONE) begin
                seen++;
                if (exp_posx.size() == 0) begin
                    errors++;
                    $display("unexpected pixel at column %0h beyond the expected stream", posx);
                end else begin
                    check("posx", exp_posx.pop_front(), posx);
                    check("pxl", exp_pxl.pop_front(), pxl);
                end
            end
        end
    end

    initial begin
        reset      = 1'b1;
        line_start = 1'b0;
        vpos       = 8'd0;
        obj_enable = 1'b1;
        prog_addr  = '0;
        prog_data  = '0;
        attr_we    = 1'b0;
        gfx_we     = 1'b0;
        pal_we     = 1'b0;
        fill_tables();
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        load_all();
        for (int i = 0; i < NUM_LINES; i++) begin
            run_line(i);
        end
        $display("lines %0d, checks %0d, errors %0d", NUM_LINES, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // bound from the line count and the load length
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, a line or a load never finished", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
obj_types_pkg.sv
video_timing_pkg.sv
obj_scan_if.sv
pixel_timer.sv
line_sequencer.sv
prog_ram.sv
obj_draw.sv
obj_engine.sv
tb_obj_engine.sv

//--- video_timing_pkg.sv
// video timing package
// slot and line timing constants of the object scan
// plus the state type of the line sequencer
`default_nettype none

package video_timing_pkg;

    localparam int SLOT_PIXELS = 16;   // enables per object slot
    localparam int NUM_SLOTS   = 32;   // object slots per line
    localparam int PIPE_DRAIN  = 24;   // enables after the last slot

    localparam logic [8:0] POSX_NONE = 9'h100;  // no pixel on this enable

    // line sequencer states
    typedef enum logic [1:0] {
        LS_IDLE  = 2'd0,   // waiting for line_start
        LS_RUN   = 2'd1,   // walking the slots
        LS_DRAIN = 2'd2    // draw pipeline emptying
    } line_state_t;

endpackage

`default_nettype wire
